// ==== rtl/geom_pkg.sv ====
/*
 * Picture geometry shared by the read-address generator and its testbench.
 * Holds the coordinate and address widths, the legal picture sizes
 * and the frame configuration word that is latched at start.
 */
package geom_pkg;

    // ========================================
    // widths and limits
    // ========================================
    localparam int COORD_W = 8;     // signed so -1 fits for the pad border
    localparam int ADDR_W  = 12;    // sram word address
    localparam int MIN_PIC = 4;     // smallest side that still holds a window
    localparam int MAX_PIC = 64;    // 64 x 64 words fill the address space

    // pixel coordinate, may go one step outside the picture
    typedef logic signed [COORD_W-1:0] coord_t;

    // ========================================
    // per-frame settings
    // ========================================
    typedef struct packed {
        logic [6:0]        pic_size;    // side of the square picture
        logic              stride_two;  // 0 means stride 1
        logic              padding;     // one pixel of zero border
        logic [ADDR_W-1:0] base_addr;   // word of pixel (0,0)
    } frame_cfg_t;

endpackage

// ==== rtl/link_pkg.sv ====
/*
 * Types that travel between the address generator stages and out on the
 * tap request link: window origin, tap offset and the request word.
 * Also holds the tap counts of the 3x3 window and the slot width.
 */
package link_pkg;

    // ========================================
    // window shape
    // ========================================
    localparam int WIN_TAPS = 9;    // taps of a full window
    localparam int ROW_TAPS = 3;    // taps per window row
    localparam int SLOT_W   = 4;    // register slot number 0..8

    // top-left corner of the current window
    typedef struct packed {
        geom_pkg::coord_t x;
        geom_pkg::coord_t y;
        logic             first_win;    // top window of a strip, fetch all rows
    } win_origin_t;

    // one tap inside the window
    typedef struct packed {
        logic [1:0] dx;
        logic [1:0] dy;
        logic       last_tap;           // column 2 of row 2
    } tap_off_t;

    // ========================================
    // outside link word
    // ========================================
    typedef struct packed {
        logic [geom_pkg::ADDR_W-1:0] addr;  // 0 for pad taps
        logic [SLOT_W-1:0]           slot;  // target in the 3x3 register array
        logic                        pad;   // tap lies outside the picture
    } tap_req_t;

endpackage

// ==== rtl/scan_walker.sv ====
/*
 * Walks the window origin over the picture. Strips go left to right,
 * windows inside a strip go downward. The origin is held until the tap
 * sequencer reports the window finished, then the next one is shown.
 */
module scan_walker (
    input  logic                  SYS_CLK,
    input  logic                  SYS_NRST,
    input  geom_pkg::frame_cfg_t  cfg_i,
    input  logic                  start_i,
    input  logic                  win_done_i,
    output link_pkg::win_origin_t win_o,
    output logic                  win_vld_o,
    output logic                  frame_end_o
);

    geom_pkg::coord_t x0_q;         // strip origin
    geom_pkg::coord_t y0_q;         // window origin inside the strip
    logic             first_q;
    logic             vld_q;
    logic             end_q;

    geom_pkg::coord_t pad_amt;      // P
    geom_pkg::coord_t step;         // S
    geom_pkg::coord_t edge_lim;     // pic_size + P
    geom_pkg::coord_t next_x;
    geom_pkg::coord_t next_y;
    logic             y_fits;
    logic             x_fits;

    // ========================================
    // next origin and bound checks
    // ========================================
    always_comb begin
        pad_amt  = cfg_i.padding ? geom_pkg::coord_t'(1) : geom_pkg::coord_t'(0);
        step     = cfg_i.stride_two ? geom_pkg::coord_t'(2) : geom_pkg::coord_t'(1);
        edge_lim = geom_pkg::coord_t'({1'b0, cfg_i.pic_size}) + pad_amt;
        next_x   = x0_q + step;
        next_y   = y0_q + step;
        // bound origin + 2 <= pic_size - 1 + P taken as origin + 3 <= pic_size + P
        y_fits   = (next_y + geom_pkg::coord_t'(link_pkg::ROW_TAPS)) <= edge_lim;
        x_fits   = (next_x + geom_pkg::coord_t'(link_pkg::ROW_TAPS)) <= edge_lim;
    end

    // ========================================
    // origin registers
    // ========================================
    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            x0_q    <= '0;
            y0_q    <= '0;
            first_q <= 1'b0;
            vld_q   <= 1'b0;
            end_q   <= 1'b0;
        end else begin
            end_q <= 1'b0;
            if (start_i) begin
                x0_q    <= -pad_amt;        // top-left, inside the border
                y0_q    <= -pad_amt;
                first_q <= 1'b1;
                vld_q   <= 1'b1;
            end else if (vld_q && win_done_i) begin
                if (y_fits) begin
                    y0_q    <= next_y;      // step down the strip
                    first_q <= 1'b0;
                end else if (x_fits) begin
                    x0_q    <= next_x;      // new strip to the right
                    y0_q    <= -pad_amt;
                    first_q <= 1'b1;
                end else begin
                    vld_q <= 1'b0;          // last window of the frame
                    end_q <= 1'b1;
                end
            end
        end
    end

    assign win_o       = '{x: x0_q, y: y0_q, first_win: first_q};
    assign win_vld_o   = vld_q;
    assign frame_end_o = end_q;

endmodule

// ==== rtl/tap_sequencer.sv ====
/*
 * Counts the taps of the current window and gives each tap's offset.
 * A first window runs all three rows, a later one only the rows that
 * are new to it (3 - stride to 2). Steps on every accepted tap.
 */
module tap_sequencer (
    input  logic                  SYS_CLK,
    input  logic                  SYS_NRST,
    input  geom_pkg::frame_cfg_t  cfg_i,
    input  link_pkg::win_origin_t win_i,
    input  logic                  win_vld_i,
    input  logic                  tap_take_i,
    output link_pkg::tap_off_t    tap_o,
    output logic                  tap_vld_o,
    output logic                  win_done_o
);

    logic [1:0] col_q;      // dx
    logic [1:0] row_k_q;    // rows done in this window
    logic [1:0] stride;
    logic [1:0] row_base;   // first dy of the window
    logic [1:0] dy;
    logic       col_last;
    logic       last;
    int         tap_idx;

    // ========================================
    // current offset
    // ========================================
    always_comb begin
        stride   = cfg_i.stride_two ? 2'd2 : 2'd1;
        row_base = win_i.first_win ? 2'd0 : 2'(link_pkg::ROW_TAPS) - stride;
        dy       = row_base + row_k_q;
        col_last = (col_q == 2'(link_pkg::ROW_TAPS - 1));
        tap_idx  = int'(dy) * link_pkg::ROW_TAPS + int'(col_q);   // row-major index
        last     = (tap_idx == link_pkg::WIN_TAPS - 1);
    end

    // ========================================
    // column / row counters
    // ========================================
    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            col_q   <= 2'd0;
            row_k_q <= 2'd0;
        end else if (tap_take_i) begin
            if (col_last) begin
                col_q <= 2'd0;
                // back to row 0 for the next window
                row_k_q <= last ? 2'd0 : row_k_q + 2'd1;
            end else begin
                col_q <= col_q + 2'd1;
            end
        end
    end

    assign tap_o      = '{dx: col_q, dy: dy, last_tap: last};
    assign tap_vld_o  = win_vld_i;             // a held window always has a tap left
    assign win_done_o = tap_take_i & last;

endmodule

// ==== rtl/addr_composer.sv ====
/*
 * Turns window origin plus tap offset into an SRAM address, a register
 * slot and a pad flag, and sends them out on a four-phase req/ack link.
 * One request is in flight while the sequencer holds the next tap.
 */
module addr_composer (
    input  logic                  SYS_CLK,
    input  logic                  SYS_NRST,
    input  geom_pkg::frame_cfg_t  cfg_i,
    input  link_pkg::win_origin_t win_i,
    input  link_pkg::tap_off_t    tap_i,
    input  logic                  tap_vld_i,
    output logic                  tap_take_o,
    input  logic                  rd_ack_i,
    output logic                  rd_req_o,
    output link_pkg::tap_req_t    tap_req_o
);

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_REQ     = 2'd1,
        ST_ACK_LOW = 2'd2
    } link_state_e;

    link_state_e                 state_q;
    link_state_e                 state_d;
    logic                        take;

    geom_pkg::coord_t            px;
    geom_pkg::coord_t            py;
    geom_pkg::coord_t            side;
    logic [geom_pkg::ADDR_W-1:0] x_ext;
    logic [geom_pkg::ADDR_W-1:0] y_ext;
    logic [geom_pkg::ADDR_W-1:0] side_ext;
    logic [geom_pkg::ADDR_W-1:0] lin_addr;
    logic                        pad;
    int                          y_row;
    int                          slot_full;
    link_pkg::tap_req_t          req_d;
    link_pkg::tap_req_t          req_q;

    // ========================================
    // pixel position, pad check, address
    // ========================================
    always_comb begin
        px   = win_i.x + geom_pkg::coord_t'({{(geom_pkg::COORD_W-2){1'b0}}, tap_i.dx});
        py   = win_i.y + geom_pkg::coord_t'({{(geom_pkg::COORD_W-2){1'b0}}, tap_i.dy});
        side = geom_pkg::coord_t'({1'b0, cfg_i.pic_size});
        pad  = px[geom_pkg::COORD_W-1] | py[geom_pkg::COORD_W-1]
             | (px >= side) | (py >= side);

        x_ext    = {{(geom_pkg::ADDR_W-geom_pkg::COORD_W){1'b0}}, px};
        y_ext    = {{(geom_pkg::ADDR_W-geom_pkg::COORD_W){1'b0}}, py};
        side_ext = {{(geom_pkg::ADDR_W-geom_pkg::COORD_W){1'b0}}, side};
        lin_addr = cfg_i.base_addr + y_ext * side_ext + x_ext;

        // row of the rotating slot table is (y + P) mod 3
        y_row     = (int'(py) + int'(cfg_i.padding)) % link_pkg::ROW_TAPS;
        slot_full = y_row * link_pkg::ROW_TAPS + int'(tap_i.dx);

        req_d.addr = pad ? '0 : lin_addr;
        req_d.slot = slot_full[link_pkg::SLOT_W-1:0];
        req_d.pad  = pad;
    end

    // ========================================
    // four-phase handshake
    // ========================================
    // a new tap is taken once the link is quiet, ack included
    assign take = tap_vld_i
                & ((state_q == ST_IDLE) | ((state_q == ST_ACK_LOW) & ~rd_ack_i));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (take) state_d = ST_REQ;
            end
            ST_REQ: begin
                if (rd_ack_i) state_d = ST_ACK_LOW;    // req drops next cycle
            end
            ST_ACK_LOW: begin
                if (take) begin
                    state_d = ST_REQ;
                end else if (!rd_ack_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request word held while req is up
    always_ff @(posedge SYS_CLK) begin
        if (take) begin
            req_q <= req_d;
        end
    end

    assign tap_take_o = take;
    assign rd_req_o   = (state_q == ST_REQ);
    assign tap_req_o  = req_q;

endmodule

// ==== rtl/rd_addr_gen.sv ====
/*
 * Read-address generator for a 3x3 convolution window.
 * start_i latches the frame config and launches one frame scan,
 * taps leave on rd_req_o / rd_ack_i and done_o pulses at the end.
 */
module rd_addr_gen (
    input  logic                 SYS_CLK,
    input  logic                 SYS_NRST,
    input  logic                 start_i,
    input  geom_pkg::frame_cfg_t cfg_i,
    input  logic                 rd_ack_i,
    output logic                 rd_req_o,
    output link_pkg::tap_req_t   tap_req_o,
    output logic                 busy_o,
    output logic                 done_o
);

    geom_pkg::frame_cfg_t  cfg_q;
    logic                  size_ok;
    logic                  start_ok;
    logic                  kick_q;      // walker starts once cfg_q is valid
    logic                  busy_q;
    logic                  end_pend_q;  // walker done, last tap still on the link
    logic                  ack_q;
    logic                  last_fall;
    logic                  done_q;

    link_pkg::win_origin_t win;
    logic                  win_vld;
    logic                  win_done;
    logic                  frame_end;
    link_pkg::tap_off_t    tap;
    logic                  tap_vld;
    logic                  tap_take;

    // ========================================
    // frame control
    // ========================================
    assign size_ok   = (int'(cfg_i.pic_size) >= geom_pkg::MIN_PIC)
                     & (int'(cfg_i.pic_size) <= geom_pkg::MAX_PIC);
    assign start_ok  = start_i & ~busy_q & size_ok;   // ignored while busy
    assign last_fall = end_pend_q & ack_q & ~rd_ack_i;

    always_ff @(posedge SYS_CLK) begin
        if (start_ok) begin
            cfg_q <= cfg_i;
        end
    end

    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            kick_q     <= 1'b0;
            busy_q     <= 1'b0;
            end_pend_q <= 1'b0;
            ack_q      <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            kick_q <= start_ok;
            ack_q  <= rd_ack_i;
            done_q <= last_fall;
            if (start_ok) begin
                busy_q <= 1'b1;
            end else if (last_fall) begin
                busy_q <= 1'b0;
            end
            if (frame_end) begin
                end_pend_q <= 1'b1;
            end else if (last_fall) begin
                end_pend_q <= 1'b0;
            end
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;

    // ========================================
    // pipeline
    // ========================================
    scan_walker u_walker (
        .SYS_CLK     (SYS_CLK),
        .SYS_NRST    (SYS_NRST),
        .cfg_i       (cfg_q),
        .start_i     (kick_q),
        .win_done_i  (win_done),
        .win_o       (win),
        .win_vld_o   (win_vld),
        .frame_end_o (frame_end)
    );

    tap_sequencer u_seq (
        .SYS_CLK    (SYS_CLK),
        .SYS_NRST   (SYS_NRST),
        .cfg_i      (cfg_q),
        .win_i      (win),
        .win_vld_i  (win_vld),
        .tap_take_i (tap_take),
        .tap_o      (tap),
        .tap_vld_o  (tap_vld),
        .win_done_o (win_done)
    );

    addr_composer u_comp (
        .SYS_CLK    (SYS_CLK),
        .SYS_NRST   (SYS_NRST),
        .cfg_i      (cfg_q),
        .win_i      (win),
        .tap_i      (tap),
        .tap_vld_i  (tap_vld),
        .tap_take_o (tap_take),
        .rd_ack_i   (rd_ack_i),
        .rd_req_o   (rd_req_o),
        .tap_req_o  (tap_req_o)
    );

endmodule

// ==== testbench/tb_clock.sv ====
/*
 * Clock and reset source for the testbench.
 * 20 unit clock period, reset held low for the first 3 cycles.
 */
module tb_clock (
    output logic SYS_CLK,
    output logic SYS_NRST
);

    initial begin
        SYS_CLK  = 1'b0;
        SYS_NRST = 1'b0;
        repeat (3) @(posedge SYS_CLK);
        SYS_NRST <= 1'b1;               // out of reset from the 3rd rising edge
    end

    always #10 SYS_CLK = ~SYS_CLK;

endmodule

// ==== testbench/rd_addr_gen_checker.sv ====
/*
 * Protocol assertions for the tap request link and the done pulse.
 * Bound into every rd_addr_gen instance at the end of this file.
 */
module rd_addr_gen_checker (
    input logic               SYS_CLK,
    input logic               SYS_NRST,
    input logic               req_i,
    input logic               ack_i,
    input link_pkg::tap_req_t tap_req_i,
    input logic               done_i
);

    int fail_cnt = 0;       // fired assertions

    // ========================================
    // four-phase link
    // ========================================
    req_held: assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST)
        req_i && !ack_i |=> req_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rd_req_o fell before rd_ack_i came");
        end

    data_held: assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST)
        req_i && !ack_i |=> $stable(tap_req_i))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("tap_req_o changed while rd_req_o was waiting for rd_ack_i");
        end

    no_early_req: assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST)
        $rose(req_i) |-> !ack_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rd_req_o rose while rd_ack_i was still high");
        end

    // frame end marker, single cycle with no request left
    done_short: assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST)
        done_i |-> !req_i ##1 !done_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("done_o was not a single pulse with the link quiet");
        end

endmodule

bind rd_addr_gen rd_addr_gen_checker u_chk (
    .SYS_CLK   (SYS_CLK),
    .SYS_NRST  (SYS_NRST),
    .req_i     (rd_req_o),
    .ack_i     (rd_ack_i),
    .tap_req_i (tap_req_o),
    .done_i    (done_o)
);

// ==== testbench/tb_rd_addr_gen.sv ====
/*
 * Testbench for the read-address generator. Frame configs come from the
 * testdata file, each frame's tap list is rebuilt from the scan and tap
 * rules, and every request is acked after a random 0..5 cycle delay.
 */
module tb_rd_addr_gen;

    localparam int WAIT_LIMIT = 50;     // cycles for any single wait

    logic                 SYS_CLK;
    logic                 SYS_NRST;
    logic                 start_i;
    geom_pkg::frame_cfg_t cfg_i;
    logic                 rd_ack_i;
    logic                 rd_req_o;
    link_pkg::tap_req_t   tap_req_o;
    logic                 busy_o;
    logic                 done_o;

    link_pkg::tap_req_t   exp_q[$];     // taps still owed in this frame
    int                   err_cnt   = 0;
    int                   tap_cnt   = 0;
    int                   frame_cnt = 0;
    int                   done_cnt  = 0;
    bit                   hung      = 1'b0;

    tb_clock u_clk (
        .SYS_CLK  (SYS_CLK),
        .SYS_NRST (SYS_NRST)
    );

    rd_addr_gen UUT (
        .SYS_CLK   (SYS_CLK),
        .SYS_NRST  (SYS_NRST),
        .start_i   (start_i),
        .cfg_i     (cfg_i),
        .rd_ack_i  (rd_ack_i),
        .rd_req_o  (rd_req_o),
        .tap_req_o (tap_req_o),
        .busy_o    (busy_o),
        .done_o    (done_o)
    );

    always @(posedge SYS_CLK) begin
        if (done_o) begin
            done_cnt <= done_cnt + 1;
        end
    end

    // ========================================
    // expected taps of one frame
    // ========================================
    task automatic build_taps(input int n, input int s, input int p, input int base);
        int                 x;
        int                 y;
        int                 a;
        int                 sl;
        bit                 pad;
        link_pkg::tap_req_t t;
        exp_q.delete();
        for (int x0 = -p; x0 + 2 <= n - 1 + p; x0 += s) begin           // strips
            for (int y0 = -p; y0 + 2 <= n - 1 + p; y0 += s) begin       // windows
                for (int dy = (y0 == -p) ? 0 : 3 - s; dy <= 2; dy++) begin
                    for (int dx = 0; dx <= 2; dx++) begin
                        x   = x0 + dx;
                        y   = y0 + dy;
                        pad = (x < 0) || (x >= n) || (y < 0) || (y >= n);
                        a   = pad ? 0 : base + y * n + x;
                        sl  = ((y + p) % 3) * 3 + dx;
                        t.addr = a[geom_pkg::ADDR_W-1:0];
                        t.slot = sl[link_pkg::SLOT_W-1:0];
                        t.pad  = pad;
                        exp_q.push_back(t);
                    end
                end
            end
        end
    endtask

    // polls at falling edges
    task automatic wait_req(input logic level, output bit ok);
        int cnt;
        cnt = 0;
        do begin
            @(negedge SYS_CLK);
            cnt++;
        end while (rd_req_o !== level && cnt < WAIT_LIMIT);
        ok = (rd_req_o === level);
        if (!ok) begin
            err_cnt++;
            $display("timeout at %0t: rd_req_o stayed at %b", $time, ~level);
        end
    endtask

    task automatic wait_done(output bit ok);
        int cnt;
        cnt = 0;
        do begin
            @(negedge SYS_CLK);
            cnt++;
        end while (done_o !== 1'b1 && cnt < WAIT_LIMIT);
        ok = (done_o === 1'b1);
        if (!ok) begin
            err_cnt++;
            $display("timeout at %0t: done_o never pulsed after the last tap", $time);
        end
    endtask

    // ========================================
    // one frame: start, ack and compare, done
    // ========================================
    task automatic run_frame(input int n, input int s, input int p, input int base);
        geom_pkg::frame_cfg_t cfg;
        geom_pkg::frame_cfg_t alt;
        link_pkg::tap_req_t   exp;
        int                   delay;
        int                   seen;
        bit                   ok;
        build_taps(n, s, p, base);
        cfg = '{pic_size: n[6:0], stride_two: (s == 2), padding: p[0],
                base_addr: base[geom_pkg::ADDR_W-1:0]};
        alt = '{pic_size: (n == 4) ? 7'd5 : 7'd4, stride_two: (s != 2), padding: ~p[0],
                base_addr: '1};
        seen = 0;
        @(posedge SYS_CLK);
        cfg_i   <= cfg;
        start_i <= 1'b1;
        @(posedge SYS_CLK);
        start_i <= 1'b0;
        while (exp_q.size() > 0 && !hung) begin
            wait_req(1'b1, ok);
            if (!ok) begin
                hung = 1'b1;
            end else begin
                exp = exp_q.pop_front();
                assert (tap_req_o === exp) else begin
                    err_cnt++;
                    $display("ERR %0t tap_req_o addr/slot/pad got %h/%0d/%b exp %h/%0d/%b",
                             $time, tap_req_o.addr, tap_req_o.slot, tap_req_o.pad,
                             exp.addr, exp.slot, exp.pad);
                end
                assert (done_cnt == frame_cnt) else begin
                    err_cnt++;
                    $display("done_o pulsed at %0t before the last tap of the frame", $time);
                end
                seen++;
                tap_cnt++;
                delay = $urandom_range(5, 0);
                repeat (delay) @(posedge SYS_CLK);
                if (seen == 4) begin
                    assert (busy_o === 1'b1) else begin
                        err_cnt++;
                        $display("ERR %0t busy_o got %b exp 1", $time, busy_o);
                    end
                    @(posedge SYS_CLK);
                    cfg_i   <= alt;             // restart while busy must change nothing
                    start_i <= 1'b1;
                    @(posedge SYS_CLK);
                    start_i <= 1'b0;
                end
                @(posedge SYS_CLK);
                rd_ack_i <= 1'b1;
                wait_req(1'b0, ok);
                @(posedge SYS_CLK);
                rd_ack_i <= 1'b0;
                hung = !ok;
            end
        end
        if (!hung) begin
            wait_done(ok);
            hung = !ok;
        end
        if (!hung) begin
            frame_cnt++;
            @(negedge SYS_CLK);
            assert (done_cnt == frame_cnt) else begin
                err_cnt++;
                $display("ERR %0t done_o pulse count got %0d exp %0d", $time, done_cnt, frame_cnt);
            end
            assert (busy_o === 1'b0 && rd_req_o === 1'b0) else begin
                err_cnt++;
                $display("ERR %0t busy_o/rd_req_o got %b/%b exp 0/0", $time, busy_o, rd_req_o);
            end
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    s;
        int    p;
        int    base;
        string line;
        void'($urandom(32'h87c6));
        start_i  = 1'b0;
        cfg_i    = '0;
        rd_ack_i = 1'b0;
        repeat (4) @(negedge SYS_CLK);      // reset spans the first 3 cycles
        assert (rd_req_o === 1'b0 && busy_o === 1'b0 && done_o === 1'b0) else begin
            err_cnt++;
            $display("ERR %0t rd_req_o/busy_o/done_o got %b/%b/%b exp 0/0/0",
                     $time, rd_req_o, busy_o, done_o);
        end
        fd = $fopen("testbench/rd_addr_gen_testdata.txt", "r");
        if (fd == 0) begin
            err_cnt++;
            $display("could not open testbench/rd_addr_gen_testdata.txt");
        end else begin
            while (!$feof(fd) && !hung) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%d %d %d %h", n, s, p, base) == 4) begin
                    run_frame(n, s, p, base);
                end
            end
            $fclose(fd);
        end
        if (frame_cnt == 0) begin
            err_cnt++;
            $display("no frame was run to the end");
        end
        $display("errors: %0d, assertion failures: %0d, frames: %0d, taps: %0d",
                 err_cnt, UUT.u_chk.fail_cnt, frame_cnt, tap_cnt);
        if (err_cnt == 0 && UUT.u_chk.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== testbench/rd_addr_gen_testdata.txt ====
# pic_size stride padding base_addr, one frame per line
# pic_size, stride (1 or 2) and padding in decimal, base_addr in hex
4 1 0 000
4 1 1 100
5 2 0 200
5 2 1 020
6 1 1 3a0
7 2 1 0ff
8 1 0 400
9 2 0 123
10 1 1 800
13 2 1 a00
16 1 0 c00
21 2 0 500
64 2 1 000
64 1 0 000

// ==== sources.f ====
rtl/geom_pkg.sv
rtl/link_pkg.sv
rtl/scan_walker.sv
rtl/tap_sequencer.sv
rtl/addr_composer.sv
rtl/rd_addr_gen.sv
testbench/tb_clock.sv
testbench/rd_addr_gen_checker.sv
testbench/tb_rd_addr_gen.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
# Exit status is 0 only when the simulation output holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_rd_addr_gen -f sources.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_rd_addr_gen +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF "All tests passed!"; then
    exit 0
fi
exit 1
